// ==== lsu_settings.svh ====
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// datapath widths.
`define LSU_DW 32
`define LSU_AW 32

// memory operation codes.
`define LSU_OP_W     4
`define LSU_OP_LD_B  4'h0
`define LSU_OP_LD_H  4'h1
`define LSU_OP_LD_W  4'h2
`define LSU_OP_LD_BU 4'h3
`define LSU_OP_LD_HU 4'h4
// ll behaves as a plain word load here.
`define LSU_OP_LL    4'h5
`define LSU_OP_ST_B  4'h8
`define LSU_OP_ST_H  4'h9
`define LSU_OP_ST_W  4'ha

`endif

// ==== lsu_pkg.sv ====
`include "lsu_settings.svh"

package lsu_pkg;

    // instruction as issued to the lsu.
    typedef struct packed {
        logic [`LSU_OP_W-1:0] op;
        logic [`LSU_AW-1:0]   base;
        logic [`LSU_AW-1:0]   offset;
        logic [`LSU_DW-1:0]   sdata;
        logic                 wreg;
        logic [4:0]           waddr;
        logic [7:0]           tag;
    } lsu_req_t;

    // address stage register, held by the load stage.
    typedef struct packed {
        logic                 valid;
        logic [`LSU_OP_W-1:0] op;
        logic [`LSU_AW-1:0]   addr;
        logic                 wreg;
        logic [4:0]           waddr;
        logic [7:0]           tag;
        logic                 is_load;
        logic                 is_store;
        logic                 access;
        logic                 excp_ale;
        logic [3:0]           wstrb;
        logic [`LSU_DW-1:0]   wdata;
    } lsu_s1_t;

    typedef struct packed {
        logic               valid;
        logic               wreg;
        logic [4:0]         waddr;
        logic [`LSU_DW-1:0] wdata;
        logic               excp_ale;
        logic [7:0]         tag;
    } lsu_wb_t;

    typedef struct packed {
        logic               wreg;
        logic               data_ok;
        logic [4:0]         waddr;
        logic [`LSU_DW-1:0] wdata;
    } lsu_fwd_t;

    typedef struct packed {
        logic [`LSU_AW-1:0] addr;
        logic               we;
        logic [3:0]         wstrb;
        logic [`LSU_DW-1:0] wdata;
    } lsu_dreq_t;

    // one memory word, viewed as byte lanes or half lanes.
    typedef union packed {
        logic [`LSU_DW/8-1:0][7:0]   bytes;
        logic [`LSU_DW/16-1:0][15:0] halves;
    } lsu_word_u;

endpackage

// ==== lsu_ctrl.sv ====
module lsu_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic flush_i,
    input  logic s1_valid_i,
    input  logic s2_valid_i,
    input  logic s2_ready_i,
    output logic advance_o,
    output logic flush_o,
    output logic clear_o
);

    logic stall;
    logic flush_q;

    // load stage still waiting on the cache.
    assign stall = s2_valid_i & ~s2_ready_i;

    // flush while an access waits, so a late answer lands one cycle on.
    always_ff @(posedge clk) begin
        if (rst) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= flush_i & stall;
        end
    end

    assign flush_o = flush_i | flush_q;

    // nothing is taken while a flush is in effect.
    assign advance_o = (s2_ready_i | ~s2_valid_i) & ~flush_o;

    // empty load stage, write-back must not repeat.
    assign clear_o = advance_o & ~s2_valid_i;

    // an accepted request is held by the load stage on the next cycle.
    a_accept_lands: assert property (
        @(posedge clk) disable iff (rst)
        (advance_o && s1_valid_i) |=> s2_valid_i
    ) else $error("lsu_ctrl: accepted request did not reach the load stage");

    // a waiting access is never dropped without a flush.
    a_stall_holds: assert property (
        @(posedge clk) disable iff (rst)
        (stall && !flush_o) |=> s2_valid_i
    ) else $error("lsu_ctrl: stalled access left the load stage");

endmodule

// ==== lsu_addr_stage.sv ====
`include "lsu_settings.svh"

module lsu_addr_stage
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     advance_i,
    input  logic     flush_i,
    input  logic     req_valid_i,
    input  lsu_req_t req_i,
    output lsu_s1_t  s1_o
);

    localparam logic [1:0] SZ_B = 2'd0;
    localparam logic [1:0] SZ_H = 2'd1;
    localparam logic [1:0] SZ_W = 2'd2;

    logic [`LSU_AW-1:0] addr;
    logic               is_load;
    logic               is_store;
    logic [1:0]         size;
    logic               excp_ale;
    lsu_word_u          st_word;
    logic [3:0]         st_strb;
    lsu_s1_t            s1_d;

    assign addr = req_i.base + req_i.offset;

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        size     = SZ_W;
        case (req_i.op)
            `LSU_OP_LD_B, `LSU_OP_LD_BU: begin
                is_load = 1'b1;
                size    = SZ_B;
            end
            `LSU_OP_LD_H, `LSU_OP_LD_HU: begin
                is_load = 1'b1;
                size    = SZ_H;
            end
            `LSU_OP_LD_W, `LSU_OP_LL: begin
                is_load = 1'b1;
            end
            `LSU_OP_ST_B: begin
                is_store = 1'b1;
                size     = SZ_B;
            end
            `LSU_OP_ST_H: begin
                is_store = 1'b1;
                size     = SZ_H;
            end
            `LSU_OP_ST_W: begin
                is_store = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // halfwords need bit 0 clear, words need bits 1:0 clear.
    assign excp_ale = (is_load | is_store) &
                      (((size == SZ_H) & addr[0]) | ((size == SZ_W) & (|addr[1:0])));

    always_comb begin
        st_word = '0;
        st_strb = 4'b0000;
        if (is_store && !excp_ale) begin
            case (size)
                SZ_B: begin
                    st_word.bytes[addr[1:0]] = req_i.sdata[7:0];
                    st_strb = 4'b0001 << addr[1:0];
                end
                SZ_H: begin
                    st_word.halves[addr[1]] = req_i.sdata[15:0];
                    st_strb = addr[1] ? 4'b1100 : 4'b0011;
                end
                default: begin
                    st_word = req_i.sdata;
                    st_strb = 4'b1111;
                end
            endcase
        end
    end

    always_comb begin
        s1_d          = '0;
        s1_d.valid    = req_valid_i;
        s1_d.op       = req_i.op;
        s1_d.addr     = addr;
        s1_d.wreg     = req_i.wreg;
        s1_d.waddr    = req_i.waddr;
        s1_d.tag      = req_i.tag;
        s1_d.is_load  = is_load;
        s1_d.is_store = is_store;
        s1_d.access   = (is_load | is_store) & ~excp_ale;
        s1_d.excp_ale = excp_ale;
        s1_d.wstrb    = st_strb;
        s1_d.wdata    = st_word;
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            s1_o.valid <= 1'b0;
        end else if (advance_i) begin
            s1_o <= s1_d;
        end
    end

    a_load_no_strb: assert property (
        @(posedge clk) disable iff (rst)
        (s1_o.valid && s1_o.is_load) |-> (s1_o.wstrb == 4'b0000)
    ) else $error("lsu_addr_stage: load carries byte strobes");

endmodule

// ==== lsu_load_stage.sv ====
`include "lsu_settings.svh"

module lsu_load_stage
    import lsu_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               advance_i,
    input  logic               flush_i,
    input  logic               clear_i,
    input  lsu_s1_t            s1_i,
    output logic               stage_ready_o,
    output logic               dreq_valid_o,
    output lsu_dreq_t          dreq_o,
    input  logic               data_ok_i,
    input  logic [`LSU_DW-1:0] rdata_i,
    output lsu_fwd_t           fwd_o,
    output lsu_wb_t            wb_o
);

    logic               access_pend;
    logic               load_pend;
    logic               answered_q;
    logic [`LSU_DW-1:0] capture_q;
    logic [1:0]         off;
    lsu_word_u          word;
    logic [`LSU_DW-1:0] ld_result;
    lsu_wb_t            wb_next;

    assign access_pend = s1_i.valid & s1_i.access;
    assign load_pend   = access_pend & s1_i.is_load;
    assign off         = s1_i.addr[1:0];

    // cache answered once for this instruction.
    always_ff @(posedge clk) begin
        if (rst || advance_i || flush_i) begin
            answered_q <= 1'b0;
        end else if (data_ok_i) begin
            answered_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (data_ok_i) begin
            capture_q <= rdata_i;
        end
    end

    assign stage_ready_o = ~access_pend | data_ok_i | answered_q;

    assign dreq_valid_o = access_pend & ~answered_q;
    assign dreq_o.addr  = s1_i.addr;
    assign dreq_o.we    = s1_i.is_store;
    assign dreq_o.wstrb = s1_i.wstrb;
    assign dreq_o.wdata = s1_i.wdata;

    // early data comes from the capture register.
    assign word = answered_q ? capture_q : rdata_i;

    always_comb begin
        ld_result = '0;
        if (load_pend) begin
            case (s1_i.op)
                `LSU_OP_LD_B: begin
                    ld_result = {{(`LSU_DW-8){word.bytes[off][7]}}, word.bytes[off]};
                end
                `LSU_OP_LD_BU: begin
                    ld_result = {{(`LSU_DW-8){1'b0}}, word.bytes[off]};
                end
                `LSU_OP_LD_H: begin
                    ld_result = {{(`LSU_DW-16){word.halves[off[1]][15]}}, word.halves[off[1]]};
                end
                `LSU_OP_LD_HU: begin
                    ld_result = {{(`LSU_DW-16){1'b0}}, word.halves[off[1]]};
                end
                default: begin
                    // word and ll.
                    ld_result = word;
                end
            endcase
        end
    end

    always_comb begin
        wb_next.valid    = s1_i.valid;
        wb_next.wreg     = s1_i.wreg & ~s1_i.excp_ale;
        wb_next.waddr    = s1_i.waddr;
        wb_next.wdata    = ld_result;
        wb_next.excp_ale = s1_i.excp_ale;
        wb_next.tag      = s1_i.tag;
    end

    assign fwd_o.wreg    = s1_i.valid & wb_next.wreg;
    assign fwd_o.data_ok = ~load_pend | data_ok_i | answered_q;
    assign fwd_o.waddr   = s1_i.waddr;
    assign fwd_o.wdata   = ld_result;

    // valid lasts one cycle, stalls drop it.
    always_ff @(posedge clk) begin
        if (rst || flush_i || clear_i) begin
            wb_o.valid <= 1'b0;
        end else if (advance_i) begin
            wb_o <= wb_next;
        end else begin
            wb_o.valid <= 1'b0;
        end
    end

    a_ok_has_req: assert property (
        @(posedge clk) disable iff (rst || flush_i)
        data_ok_i |-> dreq_valid_o
    ) else $error("lsu_load_stage: data_ok without a pending access");

endmodule

// ==== lsu_top.sv ====
`include "lsu_settings.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid_i,
    input  lsu_req_t           issue_i,
    output logic               issue_ready_o,
    input  logic               flush_i,
    output logic               dreq_valid_o,
    output lsu_dreq_t          dreq_o,
    input  logic               data_ok_i,
    input  logic [`LSU_DW-1:0] rdata_i,
    output lsu_wb_t            wb_o,
    output lsu_fwd_t           fwd_o
);

    logic    advance;
    logic    flush;
    logic    clear;
    logic    s2_ready;
    lsu_s1_t s1;

    assign issue_ready_o = advance;

    lsu_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .flush_i    (flush_i),
        .s1_valid_i (issue_valid_i),
        .s2_valid_i (s1.valid),
        .s2_ready_i (s2_ready),
        .advance_o  (advance),
        .flush_o    (flush),
        .clear_o    (clear)
    );

    lsu_addr_stage u_addr (
        .clk         (clk),
        .rst         (rst),
        .advance_i   (advance),
        .flush_i     (flush),
        .req_valid_i (issue_valid_i),
        .req_i       (issue_i),
        .s1_o        (s1)
    );

    lsu_load_stage u_load (
        .clk           (clk),
        .rst           (rst),
        .advance_i     (advance),
        .flush_i       (flush),
        .clear_i       (clear),
        .s1_i          (s1),
        .stage_ready_o (s2_ready),
        .dreq_valid_o  (dreq_valid_o),
        .dreq_o        (dreq_o),
        .data_ok_i     (data_ok_i),
        .rdata_i       (rdata_i),
        .fwd_o         (fwd_o),
        .wb_o          (wb_o)
    );

endmodule

// ==== tb_lsu_checker.sv ====
`include "lsu_settings.svh"

module tb_lsu_checker
    import lsu_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input lsu_wb_t   wb_i,
    input lsu_fwd_t  fwd_i,
    input logic      dreq_valid_i,
    input lsu_dreq_t dreq_i,
    input logic      data_ok_i,
    input logic      issue_ready_i
);

    typedef struct packed {
        logic [7:0]         tag;
        logic [4:0]         waddr;
        logic [`LSU_DW-1:0] wdata;
        logic               excp;
    } exp_t;

    exp_t exp_q[$];
    exp_t e;
    int   errors = 0;
    int   checks = 0;

    task automatic push_expected(input logic [7:0] tag, input logic [4:0] waddr,
                                 input logic [31:0] wdata, input logic excp);
        exp_t x;
        x.tag   = tag;
        x.waddr = waddr;
        x.wdata = wdata;
        x.excp  = excp;
        exp_q.push_back(x);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    // write-back compare, in issue order.
    always @(negedge clk) begin
        if (!rst && wb_i.valid) begin
            if (exp_q.size() == 0) begin
                $display("unexpected write-back for tag %0h", wb_i.tag);
                errors++;
            end else begin
                e = exp_q.pop_front();
                checks++;
                if (wb_i.tag !== e.tag) begin
                    $display("[FAIL] wb_o.tag expected %h got %h", e.tag, wb_i.tag);
                    errors++;
                end
                if (wb_i.waddr !== e.waddr) begin
                    $display("[FAIL] wb_o.waddr expected %h got %h", e.waddr, wb_i.waddr);
                    errors++;
                end
                if (wb_i.wdata !== e.wdata) begin
                    $display("[FAIL] wb_o.wdata expected %h got %h (tag %h)",
                             e.wdata, wb_i.wdata, e.tag);
                    errors++;
                end
                if (wb_i.excp_ale !== e.excp) begin
                    $display("[FAIL] wb_o.excp_ale expected %h got %h (tag %h)",
                             e.excp, wb_i.excp_ale, e.tag);
                    errors++;
                end
            end
        end
        // load stage result on the forwarding bus, once final.
        if (!rst && fwd_i.wreg && fwd_i.data_ok) begin
            if (exp_q.size() == 0) begin
                $display("forwarding bus showed a load that was never issued");
                errors++;
            end else begin
                if (fwd_i.waddr !== exp_q[0].waddr) begin
                    $display("[FAIL] fwd_o.waddr expected %h got %h",
                             exp_q[0].waddr, fwd_i.waddr);
                    errors++;
                end
                if (fwd_i.wdata !== exp_q[0].wdata) begin
                    $display("[FAIL] fwd_o.wdata expected %h got %h (tag %h)",
                             exp_q[0].wdata, fwd_i.wdata, exp_q[0].tag);
                    errors++;
                end
            end
        end
    end

    // cache port and back-pressure rules.
    always @(negedge clk) begin
        if (!rst && dreq_valid_i && !data_ok_i && issue_ready_i) begin
            $display("issue ready was high while a cache access was waiting");
            errors++;
        end
        if (!rst && dreq_valid_i && dreq_i.we) begin
            if (!((dreq_i.wstrb == (4'b0001 << dreq_i.addr[1:0])) ||
                  (dreq_i.wstrb == 4'b0011 && dreq_i.addr[1:0] == 2'd0) ||
                  (dreq_i.wstrb == 4'b1100 && dreq_i.addr[1:0] == 2'd2) ||
                  (dreq_i.wstrb == 4'b1111 && dreq_i.addr[1:0] == 2'd0))) begin
                $display("store access with strobes that do not fit its address");
                errors++;
            end
        end
    end

endmodule

// ==== tb_lsu.sv ====
`include "lsu_settings.svh"

module tb_lsu
    import lsu_pkg::*;
();

    logic        clk;
    logic        rst;
    logic        issue_valid_i;
    lsu_req_t    issue_i;
    logic        issue_ready_o;
    logic        flush_i;
    logic        dreq_valid_o;
    lsu_dreq_t   dreq_o;
    logic        data_ok_i;
    logic [31:0] rdata_i;
    lsu_wb_t     wb_o;
    lsu_fwd_t    fwd_o;

    logic [31:0] mem    [0:255];
    logic [31:0] shadow [0:255];
    logic [31:0] stim_rng;
    logic [31:0] cache_rng;
    logic [7:0]  tag;
    logic        hold;
    logic        busy;
    logic [1:0]  wait_left;
    int          accesses;
    int          fails;
    int          hung;
    int          tests_ok;
    int          tests_bad;
    int          err_start;

    lsu_top dut (
        .clk           (clk),
        .rst           (rst),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .issue_ready_o (issue_ready_o),
        .flush_i       (flush_i),
        .dreq_valid_o  (dreq_valid_o),
        .dreq_o        (dreq_o),
        .data_ok_i     (data_ok_i),
        .rdata_i       (rdata_i),
        .wb_o          (wb_o),
        .fwd_o         (fwd_o)
    );

    tb_lsu_checker chk (
        .clk           (clk),
        .rst           (rst),
        .wb_i          (wb_o),
        .fwd_i         (fwd_o),
        .dreq_valid_i  (dreq_valid_o),
        .dreq_i        (dreq_o),
        .data_ok_i     (data_ok_i),
        .issue_ready_i (issue_ready_o)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected {excp_ale, wdata} for one instruction.
    function automatic logic [32:0] expect_result(input logic [3:0] op,
                                                  input logic [31:0] addr,
                                                  input logic [31:0] word);
        logic [7:0]  b;
        logic [15:0] h;
        logic        excp;
        logic [31:0] data;
        b    = word[{addr[1:0], 3'b000} +: 8];
        h    = word[{addr[1], 4'b0000} +: 16];
        excp = 1'b0;
        data = 32'h0;
        case (op)
            `LSU_OP_LD_B:  data = {{24{b[7]}}, b};
            `LSU_OP_LD_BU: data = {24'h0, b};
            `LSU_OP_LD_H: begin
                excp = addr[0];
                data = {{16{h[15]}}, h};
            end
            `LSU_OP_LD_HU: begin
                excp = addr[0];
                data = {16'h0, h};
            end
            `LSU_OP_LD_W, `LSU_OP_LL: begin
                excp = |addr[1:0];
                data = word;
            end
            `LSU_OP_ST_H: excp = addr[0];
            `LSU_OP_ST_W: excp = |addr[1:0];
            default: begin
            end
        endcase
        if (excp) begin
            data = 32'h0;
        end
        return {excp, data};
    endfunction

    function automatic logic [31:0] store_merge(input logic [3:0] op, input logic [31:0] addr,
                                                input logic [31:0] old,
                                                input logic [31:0] sdata);
        logic [31:0] w;
        w = old;
        if (op == `LSU_OP_ST_B) begin
            w[{addr[1:0], 3'b000} +: 8] = sdata[7:0];
        end else if (op == `LSU_OP_ST_H && !addr[0]) begin
            w[{addr[1], 4'b0000} +: 16] = sdata[15:0];
        end else if (op == `LSU_OP_ST_W && addr[1:0] == 2'd0) begin
            w = sdata;
        end
        return w;
    endfunction

    // cache model with 0 to 3 cycles of latency.
    always @(posedge clk) begin
        #2;
        data_ok_i = 1'b0;
        if (rst || !dreq_valid_o) begin
            busy = 1'b0;
        end else begin
            if (!busy) begin
                busy      = 1'b1;
                cache_rng = xorshift(cache_rng);
                wait_left = cache_rng[1:0];
            end
            if (!hold) begin
                if (wait_left == 2'd0) begin
                    rdata_i = mem[dreq_o.addr[9:2]];
                    for (int k = 0; k < 4; k++) begin
                        if (dreq_o.we && dreq_o.wstrb[k]) begin
                            mem[dreq_o.addr[9:2]][8*k +: 8] = dreq_o.wdata[8*k +: 8];
                        end
                    end
                    data_ok_i = 1'b1;
                    busy      = 1'b0;
                    accesses++;
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end
    end

    task automatic note_timeout(input string what);
        $display("timeout: %s", what);
        fails++;
        hung = 1;
    endtask

    task automatic send(input logic [3:0] op, input logic [31:0] base,
                        input logic [31:0] offset, input logic [31:0] sdata,
                        input logic expect_wb);
        logic [31:0] addr;
        logic [32:0] res;
        logic        taken;
        int          t;
        addr = base + offset;
        res  = expect_result(op, addr, shadow[addr[9:2]]);
        if (op[3]) begin
            shadow[addr[9:2]] = store_merge(op, addr, shadow[addr[9:2]], sdata);
        end
        if (expect_wb) begin
            chk.push_expected(tag, tag[4:0], res[31:0], res[32]);
        end
        issue_i.op     = op;
        issue_i.base   = base;
        issue_i.offset = offset;
        issue_i.sdata  = sdata;
        issue_i.wreg   = ~op[3];
        issue_i.waddr  = tag[4:0];
        issue_i.tag    = tag;
        issue_valid_i  = 1'b1;
        taken = 1'b0;
        t = 0;
        while (!taken && t < 100) begin
            @(negedge clk);
            if (issue_ready_o) begin
                taken = 1'b1;
            end else begin
                t++;
            end
        end
        @(posedge clk);
        #2;
        issue_valid_i = 1'b0;
        tag = tag + 8'd1;
        if (!taken) begin
            note_timeout("request was never accepted");
        end
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while ((chk.pending() != 0 || dreq_valid_o) && t < 500) begin
            @(negedge clk);
            t++;
        end
        if (chk.pending() != 0 || dreq_valid_o) begin
            note_timeout("write-back queue did not drain");
        end
        @(posedge clk);
        #2;
    endtask

    task automatic end_test(input int n, input string name);
        if (chk.errors + fails == err_start) begin
            $display("test %0d %s: ok", n, name);
            tests_ok++;
        end else begin
            $display("test %0d %s: errors", n, name);
            tests_bad++;
        end
        err_start = chk.errors + fails;
    endtask

    logic [3:0] ops [0:8];
    int         acc0;

    initial begin
        ops = '{`LSU_OP_LD_B, `LSU_OP_LD_H, `LSU_OP_LD_W, `LSU_OP_LD_BU, `LSU_OP_LD_HU,
                `LSU_OP_LL, `LSU_OP_ST_B, `LSU_OP_ST_H, `LSU_OP_ST_W};
        clk = 1'b0;
        rst = 1'b1;
        issue_valid_i = 1'b0;
        issue_i = '0;
        flush_i = 1'b0;
        data_ok_i = 1'b0;
        rdata_i = 32'h0;
        stim_rng = 32'd15246;
        cache_rng = xorshift(32'd15246 ^ 32'h9e37);
        tag = 8'h0;
        hold = 1'b0;
        busy = 1'b0;
        wait_left = 2'd0;
        accesses = 0;
        fails = 0;
        hung = 0;
        tests_ok = 0;
        tests_bad = 0;
        err_start = 0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'ha5, i[7:0] + 8'h3c};
            shadow[i] = mem[i];
        end
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int i = 0; i < 8 && hung == 0; i++) begin
            stim_rng = xorshift(stim_rng);
            send(`LSU_OP_ST_W, 32'h100, 4 * i, stim_rng, 1'b1);
        end
        for (int i = 0; i < 8 && hung == 0; i++) begin
            send(`LSU_OP_LD_W, 32'h100, 4 * i, 32'h0, 1'b1);
        end
        wait_idle();
        end_test(1, "word store and load");

        if (hung == 0) begin
            send(`LSU_OP_ST_W, 32'h200, 0, 32'h8f7f80ff, 1'b1);
            send(`LSU_OP_ST_W, 32'h200, 4, 32'h7f80ff01, 1'b1);
        end
        for (int w = 0; w < 2 && hung == 0; w++) begin
            for (int o = 0; o < 4; o++) begin
                send(`LSU_OP_LD_B, 32'h200 + 4 * w, o, 32'h0, 1'b1);
                send(`LSU_OP_LD_BU, 32'h200 + 4 * w, o, 32'h0, 1'b1);
            end
            for (int o = 0; o < 4; o += 2) begin
                send(`LSU_OP_LD_H, 32'h200 + 4 * w, o, 32'h0, 1'b1);
                send(`LSU_OP_LD_HU, 32'h200 + 4 * w, o, 32'h0, 1'b1);
            end
        end
        wait_idle();
        end_test(2, "byte and half loads");

        for (int i = 0; i < 6 && hung == 0; i++) begin
            stim_rng = xorshift(stim_rng);
            send(`LSU_OP_ST_B, 32'h240, {stim_rng[4:2], 2'b00} + i % 4, stim_rng, 1'b1);
            send(`LSU_OP_ST_H, 32'h260, {stim_rng[6:4], 2'b00} + 2 * (i % 2), stim_rng, 1'b1);
        end
        for (int i = 0; i < 8 && hung == 0; i++) begin
            send(`LSU_OP_LD_W, 32'h240, 4 * i, 32'h0, 1'b1);
            send(`LSU_OP_LD_W, 32'h260, 4 * i, 32'h0, 1'b1);
        end
        wait_idle();
        end_test(3, "partial stores merge");

        acc0 = accesses;
        if (hung == 0) begin
            send(`LSU_OP_LD_H, 32'h280, 1, 32'h0, 1'b1);
            send(`LSU_OP_LD_HU, 32'h280, 3, 32'h0, 1'b1);
            send(`LSU_OP_LD_W, 32'h280, 2, 32'h0, 1'b1);
            send(`LSU_OP_LL, 32'h280, 5, 32'h0, 1'b1);
            send(`LSU_OP_ST_H, 32'h280, 1, 32'hffffffff, 1'b1);
            send(`LSU_OP_ST_W, 32'h280, 6, 32'hffffffff, 1'b1);
            wait_idle();
        end
        if (accesses != acc0) begin
            $display("misaligned access reached the cache");
            fails++;
        end
        for (int i = 0; i < 2 && hung == 0; i++) begin
            send(`LSU_OP_LD_W, 32'h280, 4 * i, 32'h0, 1'b1);
        end
        wait_idle();
        end_test(4, "misaligned accesses");

        for (int i = 0; i < 40 && hung == 0; i++) begin
            stim_rng = xorshift(stim_rng);
            send(ops[stim_rng[3:0] % 9], 32'h300, stim_rng[9:4], xorshift(stim_rng), 1'b1);
        end
        wait_idle();
        end_test(5, "random latency");

        if (hung == 0) begin
            hold = 1'b1;
            send(`LSU_OP_LD_W, 32'h100, 0, 32'h0, 1'b0);
            flush_i = 1'b1;
            @(posedge clk);
            #2;
            flush_i = 1'b0;
            hold = 1'b0;
            for (int i = 0; i < 4 && hung == 0; i++) begin
                send(`LSU_OP_LD_W, 32'h100, 4 * i, 32'h0, 1'b1);
            end
            wait_idle();
        end
        repeat (4) @(posedge clk);
        end_test(6, "flush in flight");

        $display("tests ok %0d, tests with errors %0d, checks %0d, errors %0d",
                 tests_ok, tests_bad, chk.checks, chk.errors + fails);
        if (fails == 0 && chk.errors == 0 && hung == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+.
lsu_pkg.sv
lsu_ctrl.sv
lsu_addr_stage.sv
lsu_load_stage.sv
lsu_top.sv
tb_lsu_checker.sv
tb_lsu.sv

// ==== run.sh ====
#!/bin/bash
# builds and runs the lsu testbench with verilator.
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_lsu -o tb_lsu_sim \
    && ./obj_dir/tb_lsu_sim 2>&1 | tee sim.log \
    || { echo "build or run failed"; exit 1; }

grep -q "Simulation FAILED" sim.log && { echo "failures found"; exit 1; } || exit 0
